// ==== logic/fxd_fmt_pkg.sv ====
// Number formats shared by the MAC datapath and its model
// Narrow words are Q3.13 and products and the accumulator are Q6.26
// All values are two's complement and saturate rather than wrap
`default_nettype none

package fxd_fmt_pkg;

  // ------------------------------------------------------------------
  // Word widths
  // ------------------------------------------------------------------
  localparam int DATA_W = 16;
  localparam int FRAC_W = 13;
  // Integer bits of the narrow word, sign included
  localparam int INT_W  = DATA_W - FRAC_W;
  localparam int WIDE_W = 2 * DATA_W;

  // Narrow operand and result word
  typedef logic signed [DATA_W-1:0] fxd_t;
  // Full product and accumulator word
  typedef logic signed [WIDE_W-1:0] wide_t;

  // Clamp values for both formats
  localparam fxd_t  MAX_POS_N = {1'b0, {(DATA_W-1){1'b1}}};
  localparam fxd_t  MAX_NEG_N = {1'b1, {(DATA_W-1){1'b0}}};
  localparam wide_t MAX_POS_W = {1'b0, {(WIDE_W-1){1'b1}}};
  localparam wide_t MAX_NEG_W = {1'b1, {(WIDE_W-1){1'b0}}};

  // Half a narrow LSB, added for round to nearest
  localparam wide_t RND_HALF = wide_t'({1'b1, {(FRAC_W-1){1'b0}}});

  // Stochastic rounding LFSR start value and feedback taps 15, 13, 12, 10
  localparam logic [15:0] LFSR_SEED = 16'h3285;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

endpackage

`default_nettype wire

// ==== logic/fxd_ctrl_pkg.sv ====
// Per-operation control fields of the MAC element
// Each accepted operation carries one op_ctl_t through the pipeline
// Encodings not listed below behave as OP_MUL and RND_NONE
`default_nettype none

package fxd_ctrl_pkg;

  // ------------------------------------------------------------------
  // Operation select
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,  // product only, accumulator kept
    OP_LOAD = 2'd1,  // accumulator takes the product
    OP_ACC  = 2'd2   // accumulator adds the product with clamping
  } op_e;

  // Rounding applied before the narrow truncation
  typedef enum logic [1:0] {
    RND_NONE    = 2'd0,
    RND_NEAREST = 2'd1,
    RND_STOCH   = 2'd2
  } rnd_e;

  // Control word sampled together with the operands
  typedef struct packed {
    op_e  op;
    rnd_e rnd;
  } op_ctl_t;

endpackage

`default_nettype wire

// ==== logic/lfsr16.sv ====
// Four-tap Fibonacci LFSR used as the stochastic rounding source
// Steps once per cycle with ena high and holds otherwise
// Reset loads LFSR_SEED, the state never reaches zero from there
`timescale 1ns/1ps
`default_nettype none

module lfsr16 (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        ena,
  output logic [15:0] rnd
);

  import fxd_fmt_pkg::*;

  logic [15:0] lfsr_q;
  logic        feedback;

  // XOR of the tapped bits becomes the new LSB
  assign feedback = ^(lfsr_q & LFSR_TAPS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (ena) begin
      // Whole register shifts up by one
      lfsr_q <= {lfsr_q[14:0], feedback};
    end
  end

  // Current state, valid before the next step
  assign rnd = lfsr_q;

endmodule

`default_nettype wire

// ==== logic/sat_adder.sv ====
// Combinational signed adder with clamping at the wide limits
// Overflow gives MAX_POS_W and underflow gives MAX_NEG_W
// No carry or flag output is provided
`timescale 1ns/1ps
`default_nettype none

module sat_adder (
  input  fxd_fmt_pkg::wide_t a,
  input  fxd_fmt_pkg::wide_t b,
  output fxd_fmt_pkg::wide_t sum
);

  import fxd_fmt_pkg::*;

  // One guard bit above the operands
  logic [WIDE_W:0] ext_sum;

  always_comb begin
    ext_sum = {a[WIDE_W-1], a} + {b[WIDE_W-1], b};
    // Guard bit against result sign
    case (ext_sum[WIDE_W -: 2])
      2'b01: begin
        // Two positives wrapped negative
        sum = MAX_POS_W;
      end
      2'b10: begin
        // Two negatives wrapped positive
        sum = MAX_NEG_W;
      end
      default: begin
        sum = ext_sum[WIDE_W-1:0];
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fxd_mul.sv ====
// Registered signed multiplier, Q3.13 times Q3.13 into Q6.26
// One cycle latency and a new product on every clock
// The full product fits, so no rounding or clamping happens here
`timescale 1ns/1ps
`default_nettype none

module fxd_mul (
  input  logic               clk,
  input  logic               arst_n,
  input  fxd_fmt_pkg::fxd_t  a,
  input  fxd_fmt_pkg::fxd_t  b,
  output fxd_fmt_pkg::wide_t prod
);

  import fxd_fmt_pkg::*;

  // ------------------------------------------------------------------
  // Product
  // ------------------------------------------------------------------
  wide_t prod_comb;

  // Sign extend both operands to full width before multiplying
  assign prod_comb = wide_t'(a) * wide_t'(b);

  // Maps onto the DSP output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod <= '0;
    end else begin
      // Runs freely, the valid bit travels in the control pipeline
      prod <= prod_comb;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fxd_rnd_trunc.sv ====
// Rounding and saturating truncation from Q6.26 down to Q3.13
// Rounding mode is chosen per operation through mode
// The LFSR steps on every ena, whatever the mode
// out_data holds its value while ena is low
`timescale 1ns/1ps
`default_nettype none

module fxd_rnd_trunc (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               ena,
  input  fxd_ctrl_pkg::rnd_e mode,
  input  fxd_fmt_pkg::wide_t in_data,
  output fxd_fmt_pkg::fxd_t  out_data
);

  import fxd_fmt_pkg::*;
  import fxd_ctrl_pkg::*;

  logic [15:0] rnd;
  wide_t       addend;
  wide_t       rnd_sum;
  fxd_t        trunc_val;
  logic        sgn;
  logic        sat;

  // ------------------------------------------------------------------
  // Rounding
  // ------------------------------------------------------------------
  lfsr16 lfsr_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .ena    (ena),
    .rnd    (rnd)
  );

  always_comb begin
    case (mode)
      RND_NEAREST: begin
        addend = RND_HALF;
      end
      RND_STOCH: begin
        // Low fraction bits of the state seen before this step
        addend = wide_t'({{(WIDE_W-FRAC_W){1'b0}}, rnd[FRAC_W-1:0]});
      end
      default: begin
        addend = '0;
      end
    endcase
  end

  // Clamps so rounding near the top never wraps
  sat_adder rnd_add_inst (
    .a   (in_data),
    .b   (addend),
    .sum (rnd_sum)
  );

  // ------------------------------------------------------------------
  // Truncation
  // ------------------------------------------------------------------
  // Keep bits 28 down to 13
  assign trunc_val = rnd_sum[FRAC_W +: DATA_W];
  assign sgn       = rnd_sum[WIDE_W-1];

  // Dropped integer bits must all copy the sign
  assign sat = (rnd_sum[WIDE_W-2 -: INT_W] != {INT_W{sgn}});

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_data <= '0;
    end else if (ena) begin
      if (sat) begin
        out_data <= sgn ? MAX_NEG_N : MAX_POS_N;
      end else begin
        out_data <= trunc_val;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mac_ctrl.sv ====
// Control pipeline of the MAC element
// Carries valid and the control word beside the three datapath stages
// One operation per cycle, no stall and no back-pressure
// acc_load and acc_add are only high for a valid stage-1 operation
`timescale 1ns/1ps
`default_nettype none

module mac_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  fxd_ctrl_pkg::op_ctl_t in_ctl,
  output logic                  acc_load,
  output logic                  acc_add,
  output logic                  sel_acc,
  output logic                  rnd_ena,
  output fxd_ctrl_pkg::rnd_e    rnd_mode,
  output logic                  out_valid
);

  import fxd_ctrl_pkg::*;

  // Stage 1 sits beside the multiplier register
  logic    s1_valid;
  op_ctl_t s1_ctl;
  // Stage 2 sits beside the accumulator and wide register
  logic    s2_valid;
  rnd_e    s2_rnd;
  // Stage 3 sits beside the output register
  logic    s3_valid;

  // ------------------------------------------------------------------
  // Valid and control shift
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s1_ctl   <= '{op: OP_MUL, rnd: RND_NONE};
      s2_valid <= 1'b0;
      s2_rnd   <= RND_NONE;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s1_ctl   <= in_ctl;
      s2_valid <= s1_valid;
      // Only the rounding field is needed past stage 1
      s2_rnd   <= s1_ctl.rnd;
      s3_valid <= s2_valid;
    end
  end

  // ------------------------------------------------------------------
  // Accumulator decode from the stage-1 op
  // ------------------------------------------------------------------
  always_comb begin
    acc_load = 1'b0;
    acc_add  = 1'b0;
    sel_acc  = 1'b0;
    case (s1_ctl.op)
      OP_LOAD: begin
        acc_load = s1_valid;
        sel_acc  = 1'b1;
      end
      OP_ACC: begin
        acc_add = s1_valid;
        sel_acc = 1'b1;
      end
      default: begin
        // Raw product passes, accumulator untouched
        sel_acc = 1'b0;
      end
    endcase
  end

  // Round stage works on the stage-2 operation
  assign rnd_ena   = s2_valid;
  assign rnd_mode  = s2_rnd;
  assign out_valid = s3_valid;

endmodule

`default_nettype wire

// ==== logic/fxd_mac_top.sv ====
// Fixed-point multiply-accumulate element, Q3.13 in and Q3.13 out
// Fixed latency of three cycles from in_valid to out_valid
// Results appear for one cycle only since there is no ready
// The accumulator is internal and clears to zero on reset
`timescale 1ns/1ps
`default_nettype none

module fxd_mac_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  fxd_ctrl_pkg::op_ctl_t in_ctl,
  input  fxd_fmt_pkg::fxd_t     in_a,
  input  fxd_fmt_pkg::fxd_t     in_b,
  output logic                  out_valid,
  output fxd_fmt_pkg::fxd_t     out_data
);

  import fxd_fmt_pkg::*;
  import fxd_ctrl_pkg::*;

  logic  acc_load;
  logic  acc_add;
  logic  sel_acc;
  logic  rnd_ena;
  rnd_e  rnd_mode;
  wide_t prod;
  wide_t acc_q;
  wide_t acc_sum;
  wide_t acc_next;
  wide_t s2_data;

  mac_ctrl ctrl_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ctl    (in_ctl),
    .acc_load  (acc_load),
    .acc_add   (acc_add),
    .sel_acc   (sel_acc),
    .rnd_ena   (rnd_ena),
    .rnd_mode  (rnd_mode),
    .out_valid (out_valid)
  );

  fxd_mul mul_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (in_a),
    .b      (in_b),
    .prod   (prod)
  );

  // ------------------------------------------------------------------
  // Accumulator stage
  // ------------------------------------------------------------------
  sat_adder acc_add_inst (
    .a   (acc_q),
    .b   (prod),
    .sum (acc_sum)
  );

  // Load replaces, accumulate adds with clamping
  assign acc_next = acc_load ? prod : acc_sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_q <= '0;
    end else if (acc_load || acc_add) begin
      acc_q <= acc_next;
    end
  end

  // Wide value handed to rounding, new accumulator or bare product
  always_ff @(posedge clk) begin
    s2_data <= sel_acc ? acc_next : prod;
  end

  fxd_rnd_trunc rnd_trunc_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .ena      (rnd_ena),
    .mode     (rnd_mode),
    .in_data  (s2_data),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// ==== tb/fxd_mac_model.svh ====
// Integer model of the MAC arithmetic, included inside the testbench module
// Relies on fxd_fmt_pkg and fxd_ctrl_pkg being imported by that module
// Values are worked out as plain integers and mapped back to the word types

// Full Q6.26 product, the 32-bit word always holds it
function automatic wide_t model_product(fxd_t a, fxd_t b);
  longint p;
  p = longint'(a) * longint'(b);
  return wide_t'(p);
endfunction

// Wide add clamped to the Q6.26 range
function automatic wide_t model_sat_add(wide_t a, wide_t b);
  longint s;
  s = longint'(a) + longint'(b);
  if (s > longint'(MAX_POS_W)) begin
    return MAX_POS_W;
  end else if (s < longint'(MAX_NEG_W)) begin
    return MAX_NEG_W;
  end
  return wide_t'(s);
endfunction

// One step of the Fibonacci LFSR, taps 15, 13, 12 and 10
function automatic logic [15:0] model_lfsr_step(logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// Rounding by mode, then clamped narrowing to Q3.13
function automatic fxd_t model_round_trunc(wide_t v, rnd_e mode, logic [15:0] lfsr);
  wide_t  addend;
  wide_t  r;
  longint q;
  case (mode)
    RND_NEAREST: addend = wide_t'(1 << (FRAC_W - 1));
    // Fraction part of the current LFSR state
    RND_STOCH:   addend = wide_t'(lfsr % (1 << FRAC_W));
    default:     addend = '0;
  endcase
  r = model_sat_add(v, addend);
  // Count of whole narrow LSBs, floor division by 2^13
  q = longint'(r) >>> FRAC_W;
  if (q > longint'(MAX_POS_N)) begin
    return MAX_POS_N;
  end else if (q < longint'(MAX_NEG_N)) begin
    return MAX_NEG_N;
  end
  return fxd_t'(q);
endfunction

// ==== tb/tb_fxd_mac.sv ====
// Testbench of fxd_mac_top with directed and random stimulus
// Expected results come from the integer model in fxd_mac_model.svh
// out_valid is checked on every cycle, out_data on every result
// The run stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_fxd_mac;

  import fxd_fmt_pkg::*;
  import fxd_ctrl_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 16;
  localparam int RAND_OPS    = 400;
  // Reset, directed part, random ops with up to two idle cycles each, drain
  localparam int TEST_CYCLES = RST_CYCLES + 100 + 3 * RAND_OPS + 16;

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  op_ctl_t in_ctl;
  fxd_t    in_a;
  fxd_t    in_b;
  logic    out_valid;
  fxd_t    out_data;

  // Model state, updated in issue order
  wide_t       model_acc;
  logic [15:0] model_lfsr;
  fxd_t        exp_q[$];
  // Issue history, bit 2 is the expected out_valid
  logic [2:0]  valid_hist = '0;

  `include "fxd_mac_model.svh"

  fxd_mac_top fxd_mac_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ctl    (in_ctl),
    .in_a      (in_a),
    .in_b      (in_b),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------------
  task automatic report_failure(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic compare_data(fxd_t got, fxd_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: out_data = %h, expected %h", got, exp));
    end
  endtask

  task automatic compare_valid(logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Error: out_valid = %h, expected %h", got, exp));
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  // Varied magnitudes, so only some products saturate
  function automatic fxd_t rand_operand();
    fxd_t v;
    v = fxd_t'($urandom);
    return v >>> $urandom_range(0, 5);
  endfunction

  // Drives one operation and queues the model's result for it
  task automatic issue_op(op_e op, rnd_e rnd, fxd_t a, fxd_t b);
    wide_t prod;
    wide_t wide_val;
    @(posedge clk);
    #0.5;
    in_valid   = 1'b1;
    in_ctl.op  = op;
    in_ctl.rnd = rnd;
    in_a       = a;
    in_b       = b;
    prod     = model_product(a, b);
    wide_val = prod;
    if (op == OP_LOAD) begin
      model_acc = prod;
      wide_val  = model_acc;
    end else if (op == OP_ACC) begin
      model_acc = model_sat_add(model_acc, prod);
      wide_val  = model_acc;
    end
    exp_q.push_back(model_round_trunc(wide_val, rnd, model_lfsr));
    // LFSR steps once per result, whatever the mode
    model_lfsr = model_lfsr_step(model_lfsr);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #0.5;
    in_valid = 1'b0;
    // Noise on data and control while idle
    in_ctl = op_ctl_t'(4'($urandom));
    in_a   = fxd_t'($urandom);
    in_b   = fxd_t'($urandom);
  endtask

  // ------------------------------------------------------------------
  // Scoreboard, sampled at the falling edge where outputs are stable
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    valid_hist <= {valid_hist[1:0], in_valid};
  end

  always @(negedge clk) begin
    compare_valid(out_valid, valid_hist[2]);
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("A result came out while no result was expected");
      end else begin
        compare_data(out_data, exp_q.pop_front());
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + 64));
    report_failure("Timeout, the test did not reach its end in time");
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(32'h2368_7d01));
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_ctl     = '{op: OP_MUL, rnd: RND_NONE};
    in_a       = '0;
    in_b       = '0;
    model_acc  = '0;
    model_lfsr = LFSR_SEED;
    repeat (RST_CYCLES) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    // Quiet stretch after reset
    repeat (6) idle_cycle();

    // Lone and back-to-back products, incl. narrow saturation
    issue_op(OP_MUL, RND_NONE, 16'sh2000, 16'sh2000);
    idle_cycle();
    issue_op(OP_MUL, RND_NEAREST, 16'sh0003, 16'sh1001);
    issue_op(OP_MUL, RND_NONE, 16'sh7fff, 16'sh7fff);
    issue_op(OP_MUL, RND_NEAREST, 16'sh8000, 16'sh7fff);
    issue_op(OP_MUL, RND_NEAREST, 16'sh8000, 16'sh8000);
    issue_op(OP_MUL, RND_NONE, -16'sh0123, 16'sh0456);

    // Accumulator chains, the last two clamp at the wide limits
    issue_op(OP_LOAD, RND_NEAREST, 16'sh0800, 16'sh1000);
    repeat (4) issue_op(OP_ACC, RND_NEAREST, 16'sh0c00, -16'sh0400);
    issue_op(OP_LOAD, RND_NONE, 16'sh7fff, 16'sh7fff);
    repeat (3) issue_op(OP_ACC, RND_NEAREST, 16'sh7000, 16'sh7000);
    // Back into narrow range, so the exact clamp value shows
    repeat (2) issue_op(OP_ACC, RND_NONE, 16'sh8000, 16'sh7fff);
    issue_op(OP_LOAD, RND_NONE, 16'sh8000, 16'sh7fff);
    repeat (3) issue_op(OP_ACC, RND_NONE, 16'sh8000, 16'sh7000);
    // Two times 2^30 from the negative limit lands on zero
    repeat (2) issue_op(OP_ACC, RND_NONE, 16'sh8000, 16'sh8000);
    // A product between must leave the accumulator alone
    issue_op(OP_MUL, RND_NONE, 16'sh0100, 16'sh0100);
    issue_op(OP_ACC, RND_NEAREST, 16'sh0100, 16'sh0100);

    // Stochastic rounding mixed with the other modes
    issue_op(OP_MUL, RND_STOCH, 16'sh1234, 16'sh0765);
    issue_op(OP_MUL, RND_STOCH, -16'sh0a5a, 16'sh0333);
    for (int i = 0; i < 22; i++) begin
      issue_op(OP_MUL, rnd_e'($urandom_range(0, 2)), rand_operand(), rand_operand());
    end

    // Long random mix with random gaps
    for (int n = 0; n < RAND_OPS; n++) begin
      repeat ($urandom_range(0, 2)) idle_cycle();
      issue_op(op_e'($urandom_range(0, 2)), rnd_e'($urandom_range(0, 2)),
               rand_operand(), rand_operand());
    end

    // Let the pipeline drain
    repeat (8) idle_cycle();
    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_failure($sformatf("%0d expected results never came out", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tb
logic/fxd_fmt_pkg.sv
logic/fxd_ctrl_pkg.sv
logic/lfsr16.sv
logic/sat_adder.sv
logic/fxd_mul.sv
logic/fxd_rnd_trunc.sv
logic/mac_ctrl.sv
logic/fxd_mac_top.sv
tb/tb_fxd_mac.sv
